//--- rtl/rob_pkg.sv
// ==========================================================
// Shared constants of the instruction window
// Entry count, index and tag widths, step encoding
// Circular age comparison of sequence tags
// ==========================================================

package rob_pkg;

	// Window geometry
	localparam int REB_ENTRIES = 6;
	localparam int IDX_W       = 3;

	// Index value that stands for no entry at all
	localparam logic [IDX_W-1:0] NO_ENTRY = 3'd7;

	// Sequence tags wrap modulo 64 and at most six are live
	localparam int TAG_W = 6;

	// ========================================================
	// Pipeline step of an entry
	// ========================================================
	localparam int STEP_W = 3;

	localparam logic [STEP_W-1:0] STEP_FETCHED = 3'd0;
	localparam logic [STEP_W-1:0] STEP_DECOMP  = 3'd1;
	localparam logic [STEP_W-1:0] STEP_DECODED = 3'd2;
	localparam logic [STEP_W-1:0] STEP_ISSUED  = 3'd3;
	localparam logic [STEP_W-1:0] STEP_DONE    = 3'd4;

	// True when tag a was handed out before tag b
	// The live span stays far below half the tag space, so the sign
	// of the wrapped difference gives the order
	function automatic logic seq_older(
		input logic [TAG_W-1:0] a,
		input logic [TAG_W-1:0] b
	);
		logic [TAG_W-1:0] diff;
		diff = a - b;
		return diff[TAG_W-1];
	endfunction

endpackage

//--- rtl/rob_alloc.sv
// ==========================================================
// Entry allocator of the instruction window
// Finds the two lowest free entries, drives the ready flags
// and keeps the running sequence tag counter
// ==========================================================

`timescale 1ns/100ps

module rob_alloc (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [rob_pkg::REB_ENTRIES-1:0] valid_bits,
	input  logic                            in_valid0,
	input  logic                            in_valid1,
	output logic [rob_pkg::REB_ENTRIES-1:0] alloc,
	output logic [rob_pkg::REB_ENTRIES-1:0] alloc_slot,
	output logic                            in_ready0,
	output logic                            in_ready1,
	output logic [rob_pkg::TAG_W-1:0]       out_tag0,
	output logic [rob_pkg::TAG_W-1:0]       out_tag1
);
	import rob_pkg::*;

	logic [IDX_W-1:0] first_free;
	logic [IDX_W-1:0] second_free;
	logic             take0;
	logic             take1;
	logic [TAG_W-1:0] next_tag;

	// Scan upward for the first two empty entries
	// Either index stays at NO_ENTRY when the window has no room for it
	always_comb begin
		first_free  = NO_ENTRY;
		second_free = NO_ENTRY;
		for (int i = 0; i < REB_ENTRIES; i++) begin
			if (!valid_bits[i]) begin
				if (first_free == NO_ENTRY)
					first_free = IDX_W'(i);
				else if (second_free == NO_ENTRY)
					second_free = IDX_W'(i);
			end
		end
	end

	assign in_ready0 = (first_free != NO_ENTRY);
	assign in_ready1 = (second_free != NO_ENTRY);

	// Slot 1 only goes in alongside slot 0
	assign take0 = in_valid0 && in_ready0;
	assign take1 = take0 && in_valid1 && in_ready1;

	// Slot 0 lands in the lower free entry, slot 1 in the next one up
	always_comb begin
		for (int i = 0; i < REB_ENTRIES; i++) begin
			alloc[i]      = (take0 && first_free == IDX_W'(i)) ||
			                (take1 && second_free == IDX_W'(i));
			alloc_slot[i] = take1 && second_free == IDX_W'(i);
		end
	end

	// ========================================================
	// Sequence tag counter
	// ========================================================

	// A flush leaves the counter alone, so flushed tags are never reused early
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			next_tag <= '0;
		else
			next_tag <= next_tag + TAG_W'(take0) + TAG_W'(take1);
	end

	assign out_tag0 = next_tag;
	assign out_tag1 = next_tag + TAG_W'(1);

endmodule

//--- rtl/rob_entry.sv
// ==========================================================
// One reorder-buffer entry
// Holds the class flags, sequence tag and pipeline step
// and steps forward on the scheduler's grant strobes
// ==========================================================

`timescale 1ns/100ps

module rob_entry (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       alloc,
	input  logic [rob_pkg::TAG_W-1:0]  alloc_tag,
	input  logic                       alloc_mem,
	input  logic                       alloc_flowchg,
	input  logic                       grant_decomp,
	input  logic                       grant_decode,
	input  logic                       grant_issue,
	input  logic                       mem_complete,
	input  logic                       retire,
	input  logic                       flush,
	input  logic [rob_pkg::TAG_W-1:0]  flush_tag,
	output logic                       valid,
	output logic [rob_pkg::STEP_W-1:0] step,
	output logic                       is_mem,
	output logic                       is_flowchg,
	output logic [rob_pkg::TAG_W-1:0]  tag
);
	import rob_pkg::*;

	logic kill;

	// A flush drops this entry when it came after the flush point
	assign kill = flush && valid && seq_older(flush_tag, tag);

	// ========================================================
	// Valid bit and step
	// ========================================================

	// Allocation only ever hits a free entry and grants only a live one,
	// so the two never meet on the same edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= 1'b0;
			step  <= STEP_FETCHED;
		end else if (alloc) begin
			valid <= 1'b1;
			step  <= STEP_FETCHED;
		end else if (retire || kill) begin
			valid <= 1'b0;
		end else if (grant_decomp) begin
			step <= STEP_DECOMP;
		end else if (grant_decode) begin
			step <= STEP_DECODED;
		end else if (grant_issue) begin
			// Non-memory work finishes as it issues
			step <= is_mem ? STEP_ISSUED : STEP_DONE;
		end else if (mem_complete) begin
			step <= STEP_DONE;
		end
	end

	// Instruction payload, captured once when the entry is filled
	always_ff @(posedge clk) begin
		if (alloc) begin
			tag        <= alloc_tag;
			is_mem     <= alloc_mem;
			is_flowchg <= alloc_flowchg;
		end
	end

endmodule

//--- rtl/rob_sched.sv
// ==========================================================
// Step scheduler of the instruction window
// Grants decompress, decode and issue to one entry each
// Retires up to two finished entries in tag order
// ==========================================================

`timescale 1ns/100ps

module rob_sched (
	input  logic [rob_pkg::REB_ENTRIES-1:0]                      valid,
	input  logic [rob_pkg::REB_ENTRIES-1:0][rob_pkg::STEP_W-1:0] step,
	input  logic [rob_pkg::REB_ENTRIES-1:0]                      is_mem,
	input  logic [rob_pkg::REB_ENTRIES-1:0]                      is_flowchg,
	input  logic [rob_pkg::REB_ENTRIES-1:0][rob_pkg::TAG_W-1:0]  tag,
	input  logic                                                 mem_done,
	output logic [rob_pkg::REB_ENTRIES-1:0]                      grant_decomp,
	output logic [rob_pkg::REB_ENTRIES-1:0]                      grant_decode,
	output logic [rob_pkg::REB_ENTRIES-1:0]                      grant_issue,
	output logic [rob_pkg::REB_ENTRIES-1:0]                      mem_complete,
	output logic [rob_pkg::REB_ENTRIES-1:0]                      retire,
	output logic                                                 issue_valid,
	output logic [rob_pkg::TAG_W-1:0]                            issue_tag,
	output logic                                                 issue_mem,
	output logic                                                 retire_valid0,
	output logic                                                 retire_valid1,
	output logic [rob_pkg::TAG_W-1:0]                            retire_tag0,
	output logic [rob_pkg::TAG_W-1:0]                            retire_tag1
);
	import rob_pkg::*;

	typedef logic [REB_ENTRIES-1:0] vec_t;
	typedef logic [REB_ENTRIES-1:0][TAG_W-1:0] tags_t;

	// Lowest set bit of a mask, as a one-hot vector
	function automatic vec_t lowest_oh(input vec_t mask);
		vec_t oh;
		oh = '0;
		for (int i = REB_ENTRIES - 1; i >= 0; i--)
			if (mask[i])
				oh = vec_t'(1) << i;
		return oh;
	endfunction

	// Entry in the mask holding the oldest tag, as a one-hot vector
	function automatic vec_t oldest_oh(input vec_t mask, input tags_t tags);
		vec_t             oh;
		logic [TAG_W-1:0] best;
		logic             found;
		oh    = '0;
		best  = '0;
		found = 1'b0;
		for (int i = 0; i < REB_ENTRIES; i++) begin
			if (mask[i] && (!found || seq_older(tags[i], best))) begin
				oh    = vec_t'(1) << i;
				best  = tags[i];
				found = 1'b1;
			end
		end
		return oh;
	endfunction

	// Tag of the entry chosen by a one-hot vector, zero when none is
	function automatic logic [TAG_W-1:0] pick_tag(input vec_t oh, input tags_t tags);
		logic [TAG_W-1:0] t;
		t = '0;
		for (int i = 0; i < REB_ENTRIES; i++)
			if (oh[i])
				t = t | tags[i];
		return t;
	endfunction

	vec_t fetched_v;
	vec_t decomp_v;
	vec_t decoded_v;
	vec_t issued_v;
	vec_t done_v;
	vec_t fc_block;
	vec_t mem_block;
	vec_t issue_ok;
	vec_t head0;
	vec_t head1;
	logic mem_busy;

	// Per-entry step flags, always qualified by the valid bit
	always_comb begin
		for (int i = 0; i < REB_ENTRIES; i++) begin
			fetched_v[i] = valid[i] && step[i] == STEP_FETCHED;
			decomp_v[i]  = valid[i] && step[i] == STEP_DECOMP;
			decoded_v[i] = valid[i] && step[i] == STEP_DECODED;
			issued_v[i]  = valid[i] && step[i] == STEP_ISSUED;
			done_v[i]    = valid[i] && step[i] == STEP_DONE;
		end
	end

	// ========================================================
	// Decompress and decode, lowest index first
	// ========================================================
	assign grant_decomp = lowest_oh(fetched_v);
	assign grant_decode = lowest_oh(decomp_v);

	// ========================================================
	// Issue
	// ========================================================

	// Look for older flow changes and older memory operations still in flight
	always_comb begin
		fc_block  = '0;
		mem_block = '0;
		for (int k = 0; k < REB_ENTRIES; k++) begin
			for (int j = 0; j < REB_ENTRIES; j++) begin
				if (valid[j] && !done_v[j] && seq_older(tag[j], tag[k])) begin
					if (is_flowchg[j])
						fc_block[k] = 1'b1;
					if (is_mem[j])
						mem_block[k] = 1'b1;
				end
			end
		end
	end

	// Only one memory operation may be outstanding at a time
	assign mem_busy = |issued_v;

	// Memory ops wait on older flow changes and older memory ops
	// Flow changes wait on older flow changes, everything else goes
	assign issue_ok = decoded_v &
	                  ~((is_mem | is_flowchg) & fc_block) &
	                  ~(is_mem & (mem_block | {REB_ENTRIES{mem_busy}}));

	assign grant_issue = oldest_oh(issue_ok, tag);
	assign issue_valid = |grant_issue;
	assign issue_tag   = pick_tag(grant_issue, tag);
	assign issue_mem   = |(grant_issue & is_mem);

	// The external done pulse lands on the one issued memory entry
	assign mem_complete = mem_done ? issued_v : '0;

	// ========================================================
	// Retire, in tag order and at most two per cycle
	// ========================================================
	assign head0 = oldest_oh(valid, tag);
	assign head1 = oldest_oh(valid & ~head0, tag);

	// The second slot retires only behind a retiring head
	assign retire_valid0 = |(head0 & done_v);
	assign retire_valid1 = retire_valid0 && |(head1 & done_v);
	assign retire_tag0   = pick_tag(head0, tag);
	assign retire_tag1   = pick_tag(head1, tag);

	assign retire = (retire_valid0 ? head0 : '0) | (retire_valid1 ? head1 : '0);

endmodule

//--- rtl/rob_window.sv
// ==========================================================
// Top level of the instruction window
// Allocator, six reorder-buffer entries and the scheduler
// ==========================================================

`timescale 1ns/100ps

module rob_window (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      in_valid0,
	input  logic                      in_valid1,
	input  logic                      in_mem0,
	input  logic                      in_mem1,
	input  logic                      in_flowchg0,
	input  logic                      in_flowchg1,
	output logic                      in_ready0,
	output logic                      in_ready1,
	output logic [rob_pkg::TAG_W-1:0] out_tag0,
	output logic [rob_pkg::TAG_W-1:0] out_tag1,
	input  logic                      mem_done,
	input  logic                      flush,
	input  logic [rob_pkg::TAG_W-1:0] flush_tag,
	output logic                      issue_valid,
	output logic [rob_pkg::TAG_W-1:0] issue_tag,
	output logic                      issue_mem,
	output logic                      retire_valid0,
	output logic                      retire_valid1,
	output logic [rob_pkg::TAG_W-1:0] retire_tag0,
	output logic [rob_pkg::TAG_W-1:0] retire_tag1
);
	import rob_pkg::*;

	logic [REB_ENTRIES-1:0]             alloc;
	logic [REB_ENTRIES-1:0]             alloc_slot;
	logic [REB_ENTRIES-1:0]             valid_bits;
	logic [REB_ENTRIES-1:0][STEP_W-1:0] step_v;
	logic [REB_ENTRIES-1:0]             mem_v;
	logic [REB_ENTRIES-1:0]             fc_v;
	logic [REB_ENTRIES-1:0][TAG_W-1:0]  tag_v;
	logic [REB_ENTRIES-1:0]             grant_decomp;
	logic [REB_ENTRIES-1:0]             grant_decode;
	logic [REB_ENTRIES-1:0]             grant_issue;
	logic [REB_ENTRIES-1:0]             mem_complete;
	logic [REB_ENTRIES-1:0]             retire;

	rob_alloc u_alloc (
		.clk        (clk),
		.arst_n     (arst_n),
		.valid_bits (valid_bits),
		.in_valid0  (in_valid0),
		.in_valid1  (in_valid1),
		.alloc      (alloc),
		.alloc_slot (alloc_slot),
		.in_ready0  (in_ready0),
		.in_ready1  (in_ready1),
		.out_tag0   (out_tag0),
		.out_tag1   (out_tag1)
	);

	// Each entry takes slot 0 or slot 1 data as the allocator selects
	for (genvar i = 0; i < REB_ENTRIES; i++) begin : g_entry
		rob_entry u_entry (
			.clk           (clk),
			.arst_n        (arst_n),
			.alloc         (alloc[i]),
			.alloc_tag     (alloc_slot[i] ? out_tag1 : out_tag0),
			.alloc_mem     (alloc_slot[i] ? in_mem1 : in_mem0),
			.alloc_flowchg (alloc_slot[i] ? in_flowchg1 : in_flowchg0),
			.grant_decomp  (grant_decomp[i]),
			.grant_decode  (grant_decode[i]),
			.grant_issue   (grant_issue[i]),
			.mem_complete  (mem_complete[i]),
			.retire        (retire[i]),
			.flush         (flush),
			.flush_tag     (flush_tag),
			.valid         (valid_bits[i]),
			.step          (step_v[i]),
			.is_mem        (mem_v[i]),
			.is_flowchg    (fc_v[i]),
			.tag           (tag_v[i])
		);
	end

	rob_sched u_sched (
		.valid         (valid_bits),
		.step          (step_v),
		.is_mem        (mem_v),
		.is_flowchg    (fc_v),
		.tag           (tag_v),
		.mem_done      (mem_done),
		.grant_decomp  (grant_decomp),
		.grant_decode  (grant_decode),
		.grant_issue   (grant_issue),
		.mem_complete  (mem_complete),
		.retire        (retire),
		.issue_valid   (issue_valid),
		.issue_tag     (issue_tag),
		.issue_mem     (issue_mem),
		.retire_valid0 (retire_valid0),
		.retire_valid1 (retire_valid1),
		.retire_tag0   (retire_tag0),
		.retire_tag1   (retire_tag1)
	);

endmodule

//--- verification/rob_window_properties.sv
// ==========================================================
// Concurrent checks on the instruction window ports
// Reset state, single outstanding memory op, ready flags
// Bind of the checker onto the window top level
// ==========================================================

`timescale 1ns/100ps

module rob_window_properties (
	input logic                            clk,
	input logic                            arst_n,
	input logic                            in_ready0,
	input logic                            in_ready1,
	input logic [rob_pkg::TAG_W-1:0]       out_tag0,
	input logic                            issue_valid,
	input logic                            issue_mem,
	input logic                            retire_valid0,
	input logic                            retire_valid1,
	input logic                            mem_done,
	input logic [rob_pkg::REB_ENTRIES-1:0] valid_bits
);
	import rob_pkg::*;

	// Set by a memory issue, cleared by the done pulse that follows it
	logic mem_open;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem_open <= 1'b0;
		else if (issue_valid && issue_mem)
			mem_open <= 1'b1;
		else if (mem_done)
			mem_open <= 1'b0;
	end

	// First edge out of reset sees an empty window and tag zero
	a_reset_state: assert property (@(posedge clk)
		$rose(arst_n) |-> (!issue_valid && !retire_valid0 && !retire_valid1 &&
		                   in_ready0 && in_ready1 && out_tag0 == '0))
		else $error("window not idle on the first edge after reset");

	// A second memory issue has to wait for the done pulse
	a_one_mem: assert property (@(posedge clk) disable iff (!arst_n)
		mem_open |-> !(issue_valid && issue_mem))
		else $error("memory issue while another memory op is outstanding");

	// Ready flags follow the live entry count
	a_ready0: assert property (@(posedge clk) disable iff (!arst_n)
		(!in_ready0) == ($countones(valid_bits) == REB_ENTRIES))
		else $error("in_ready0 does not match a full window");

	a_ready1: assert property (@(posedge clk) disable iff (!arst_n)
		(!in_ready1) == ($countones(valid_bits) >= REB_ENTRIES - 1))
		else $error("in_ready1 does not match five or more live entries");

endmodule

bind rob_window rob_window_properties props0 (
	.clk           (clk),
	.arst_n        (arst_n),
	.in_ready0     (in_ready0),
	.in_ready1     (in_ready1),
	.out_tag0      (out_tag0),
	.issue_valid   (issue_valid),
	.issue_mem     (issue_mem),
	.retire_valid0 (retire_valid0),
	.retire_valid1 (retire_valid1),
	.mem_done      (mem_done),
	.valid_bits    (valid_bits)
);

//--- verification/rob_window_tb.sv
// ==========================================================
// Testbench of the instruction window
// Clock, reset, random stimulus and flushes
// Queue model of live tags with issue and retire checks
// ==========================================================

`timescale 1ns/100ps

module rob_window_tb;
	import rob_pkg::*;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             mem;
		logic             fc;
		logic             iss;
		logic             exe;
	} live_t;

	logic clk = 1'b0;
	logic arst_n, in_valid0, in_valid1, in_mem0, in_mem1, in_flowchg0, in_flowchg1;
	logic mem_done, flush;
	logic [TAG_W-1:0] flush_tag, out_tag0, out_tag1, issue_tag, retire_tag0, retire_tag1;
	logic in_ready0, in_ready1, issue_valid, issue_mem, retire_valid0, retire_valid1;

	// Live instructions, oldest first, and tags removed by a flush
	live_t              live_q[$];
	logic [2**TAG_W-1:0] flushed;
	logic [TAG_W-1:0]    model_tag;

	always #2 clk = ~clk;

	rob_window dut0 (
		.clk(clk), .arst_n(arst_n), .in_valid0(in_valid0), .in_valid1(in_valid1),
		.in_mem0(in_mem0), .in_mem1(in_mem1), .in_flowchg0(in_flowchg0),
		.in_flowchg1(in_flowchg1), .in_ready0(in_ready0), .in_ready1(in_ready1),
		.out_tag0(out_tag0), .out_tag1(out_tag1), .mem_done(mem_done), .flush(flush),
		.flush_tag(flush_tag), .issue_valid(issue_valid), .issue_tag(issue_tag),
		.issue_mem(issue_mem), .retire_valid0(retire_valid0), .retire_valid1(retire_valid1),
		.retire_tag0(retire_tag0), .retire_tag1(retire_tag1)
	);

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	function automatic int find_live(input logic [TAG_W-1:0] t);
		for (int i = 0; i < live_q.size(); i++)
			if (live_q[i].tag == t)
				return i;
		return -1;
	endfunction

	// Drives the stimulus on the falling edge
	// With feed low only the done pulse keeps going
	task automatic drive_inputs(input bit feed);
		int k;
		logic busy;
		in_valid0   = feed && ($urandom_range(0, 3) != 0);
		in_valid1   = feed && ($urandom_range(0, 1) != 0);
		in_mem0     = ($urandom_range(0, 2) == 0);
		in_mem1     = ($urandom_range(0, 2) == 0);
		in_flowchg0 = ($urandom_range(0, 3) == 0);
		in_flowchg1 = ($urandom_range(0, 3) == 0);
		mem_done    = ($urandom_range(0, 3) == 0);
		flush       = 1'b0;
		flush_tag   = '0;
		if (feed && live_q.size() > 0 && $urandom_range(0, 24) == 0) begin
			k = $urandom_range(0, live_q.size() - 1);
			// Never cut off the outstanding memory op or one issuing this cycle
			for (int m = 0; m < live_q.size(); m++) begin
				busy = live_q[m].iss && !live_q[m].exe;
				busy = busy || (issue_valid && live_q[m].tag == issue_tag);
				if (live_q[m].mem && busy && m > k)
					k = m;
			end
			flush     = 1'b1;
			flush_tag = live_q[k].tag;
		end
	endtask

	// Checks the cycle's outputs just before the rising edge, then moves the model
	task automatic check_cycle();
		int               k;
		int               fi;
		live_t            e;
		logic [TAG_W-1:0] diff;
		k = -1;
		assert (out_tag0 == model_tag)
			else report_error($sformatf("out_tag0 %0d, expected %0d", out_tag0, model_tag));
		assert (out_tag1 == model_tag + 6'd1)
			else report_error($sformatf("out_tag1 %0d, expected %0d", out_tag1,
			                            model_tag + 6'd1));
		if (issue_valid) begin
			k = find_live(issue_tag);
			assert (!flushed[issue_tag])
				else report_error($sformatf("issue of flushed tag %0d", issue_tag));
			assert (k >= 0)
				else report_error($sformatf("issue of tag %0d, which is not live", issue_tag));
			assert (issue_mem == live_q[k].mem)
				else report_error($sformatf("issue_mem wrong for tag %0d", issue_tag));
			for (int j = 0; j < k; j++) begin
				assert (!((issue_mem || live_q[k].fc) && live_q[j].fc && !live_q[j].exe))
					else report_error($sformatf("tag %0d issued past flow change %0d",
					                            issue_tag, live_q[j].tag));
				assert (!(issue_mem && live_q[j].mem && !live_q[j].iss))
					else report_error($sformatf("memory tag %0d issued before %0d",
					                            issue_tag, live_q[j].tag));
			end
		end
		if (retire_valid0) begin
			assert (!flushed[retire_tag0])
				else report_error($sformatf("retire of flushed tag %0d", retire_tag0));
			assert (live_q.size() > 0 && retire_tag0 == live_q[0].tag)
				else report_error($sformatf("retire_tag0 %0d out of order", retire_tag0));
		end
		if (retire_valid1) begin
			diff = retire_tag0 - retire_tag1;
			assert (!flushed[retire_tag1])
				else report_error($sformatf("retire of flushed tag %0d", retire_tag1));
			assert (retire_valid0 && live_q.size() > 1 && retire_tag1 == live_q[1].tag &&
			        diff[TAG_W-1])
				else report_error($sformatf("retire_tag1 %0d out of order", retire_tag1));
		end
		// The done pulse finishes the memory op that was already outstanding
		if (mem_done)
			for (int j = 0; j < live_q.size(); j++)
				if (live_q[j].mem && live_q[j].iss && !live_q[j].exe) begin
					e         = live_q[j];
					e.exe     = 1'b1;
					live_q[j] = e;
				end
		if (issue_valid) begin
			e         = live_q[k];
			e.iss     = 1'b1;
			e.exe     = !e.mem;
			live_q[k] = e;
		end
		if (retire_valid0)
			void'(live_q.pop_front());
		if (retire_valid1)
			void'(live_q.pop_front());
		// A missing flush tag means it just retired, so everything left is younger
		if (flush) begin
			fi = find_live(flush_tag);
			while (live_q.size() > fi + 1) begin
				e              = live_q.pop_back();
				flushed[e.tag] = 1'b1;
			end
		end
		if (in_valid0 && in_ready0) begin
			e = '{tag: model_tag, mem: in_mem0, fc: in_flowchg0, iss: 1'b0, exe: 1'b0};
			live_q.push_back(e);
			flushed[model_tag] = 1'b0;
			model_tag          = model_tag + 6'd1;
			if (in_valid1 && in_ready1) begin
				e = '{tag: model_tag, mem: in_mem1, fc: in_flowchg1, iss: 1'b0, exe: 1'b0};
				live_q.push_back(e);
				flushed[model_tag] = 1'b0;
				model_tag          = model_tag + 6'd1;
			end
		end
	endtask

	initial begin
		int waited;
		void'($urandom(32'h44d4_77c9));
		arst_n = 1'b0;
		{in_valid0, in_valid1, in_mem0, in_mem1, in_flowchg0, in_flowchg1} = '0;
		{mem_done, flush} = '0;
		flush_tag = '0;
		flushed   = '0;
		model_tag = '0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		for (int c = 0; c < 3000; c++) begin
			@(negedge clk);
			drive_inputs(1'b1);
			#1;
			check_cycle();
		end
		// Drain with no new instructions until the model is empty
		waited = 0;
		while (live_q.size() != 0 && waited < 300) begin
			@(negedge clk);
			drive_inputs(1'b0);
			#1;
			check_cycle();
			waited++;
		end
		if (live_q.size() != 0) begin
			$display("Timeout: the window did not drain within %0d cycles", waited);
			stop_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- rob_window.f
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry.sv
rtl/rob_sched.sv
rtl/rob_window.sv
verification/rob_window_properties.sv
verification/rob_window_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the instruction window testbench with Verilator, runs it,
# and decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rob_window.f \
	--top-module rob_window_tb -Mdir obj_dir -o rob_window_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/rob_window_sim > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1
